/* all.f */
common/gnss_pkg.sv
rtl/sample_quantizer.sv
rtl/epoch_timer.sv
capture/capture_ram.sv
capture/capture_ctrl.sv
rtl/gnss_frontend_top.sv
test/tb_gnss_frontend.sv

/* capture/capture_ctrl.sv */
/* capture FSM: arm on start, align to the next epoch, decimate into the ram,
   then drain the ram in write order over a valid/ready port. */
`timescale 1ns/100ps

module capture_ctrl #(
    parameter int capt_depth = gnss_pkg::DEFAULT_CAPT_DEPTH
) (
    input  logic                          adcclk,
    input  logic                          arst_n,
    input  logic                          start,
    input  gnss_pkg::dec_t                dec,
    input  logic                          bb_valid,
    input  gnss_pkg::bb_sample_t          bb_imag,
    input  gnss_pkg::bb_sample_t          bb_real,
    input  logic                          epoch,
    input  gnss_pkg::capture_word_t       rd_data,
    input  logic                          cap_ready,
    output logic                          busy,
    output logic                          done,
    output logic                          wr_en,
    output logic [$clog2(capt_depth)-1:0] wr_addr,
    output gnss_pkg::capture_word_t       wr_data,
    output logic                          rd_en,
    output logic [$clog2(capt_depth)-1:0] rd_addr,
    output logic                          cap_valid,
    output gnss_pkg::capture_word_t       cap_data
);

    localparam int aw = $clog2(capt_depth);
    localparam logic [aw-1:0] last_addr = aw'(capt_depth - 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_armed = 2'd1;
    localparam logic [1:0] st_fill  = 2'd2;
    localparam logic [1:0] st_drain = 2'd3;

    logic [1:0]     state;
    gnss_pkg::dec_t dec_lat;
    gnss_pkg::dec_t dec_cnt;
    logic [aw-1:0]  addr;
    logic           rd_last;
    logic           last_take;

    assign busy = (state != st_idle);

    // fill and drain never overlap, so one pointer serves both ports.
    assign wr_addr = addr;
    assign rd_addr = addr;

    // store when the decimation count has run down.
    assign wr_en = (state == st_fill) && bb_valid && (dec_cnt == '0);

    always_comb begin
        wr_data.iq.im = bb_imag;
        wr_data.iq.re = bb_real;
    end

    // the ram output register is the output word.
    // a read only goes out when that word is empty or leaving this cycle.
    assign rd_en     = (state == st_drain) && !rd_last && (!cap_valid || cap_ready);
    assign cap_data  = rd_data;
    // rd_last set means the word on the port is the final one.
    assign last_take = rd_last && cap_valid && cap_ready;

    always_ff @(posedge adcclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            dec_lat   <= '0;
            dec_cnt   <= '0;
            addr      <= '0;
            rd_last   <= 1'b0;
            cap_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    // dec is latched only here.
                    if (start) begin
                        state   <= st_armed;
                        dec_lat <= dec;
                        done    <= 1'b0;
                    end
                end
                st_armed: begin
                    // the epoch sample itself is skipped and the next one is stored.
                    if (epoch) begin
                        state   <= st_fill;
                        dec_cnt <= '0;
                    end
                end
                st_fill: begin
                    if (bb_valid) begin
                        if (dec_cnt == '0) begin
                            dec_cnt <= dec_lat;
                            if (addr == last_addr) begin
                                addr  <= '0;
                                state <= st_drain;
                            end else begin
                                addr <= addr + 1'b1;
                            end
                        end else begin
                            dec_cnt <= dec_cnt - 1'b1;
                        end
                    end
                end
                st_drain: begin
                    if (rd_en) begin
                        cap_valid <= 1'b1;
                        if (addr == last_addr) begin
                            addr    <= '0;
                            rd_last <= 1'b1;
                        end else begin
                            addr <= addr + 1'b1;
                        end
                    end else if (cap_ready) begin
                        cap_valid <= 1'b0;
                    end
                    // final handshake closes the capture.
                    if (last_take) begin
                        state   <= st_idle;
                        rd_last <= 1'b0;
                        done    <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // a stalled word stays put until taken.
    a_stall_hold: assert property (
        @(posedge adcclk) disable iff (!arst_n)
        (cap_valid && !cap_ready) |=> (cap_valid && $stable(cap_data))
    );

    // pointer stays inside the ram even for depths that are not a power of two.
    a_addr_range: assert property (
        @(posedge adcclk) disable iff (!arst_n)
        int'(addr) < capt_depth
    );

endmodule

/* capture/capture_ram.sv */
/* single-clock capture memory, one write port and one registered read port.
   holds raw bytes, the read word keeps its value while rd_en is low. */
`timescale 1ns/100ps

module capture_ram #(
    parameter int capt_depth = gnss_pkg::DEFAULT_CAPT_DEPTH
) (
    input  logic                          adcclk,
    input  logic                          wr_en,
    input  logic [$clog2(capt_depth)-1:0] wr_addr,
    input  gnss_pkg::capture_word_t       wr_data,
    input  logic                          rd_en,
    input  logic [$clog2(capt_depth)-1:0] rd_addr,
    output gnss_pkg::capture_word_t       rd_data
);

    localparam int dw = $bits(gnss_pkg::capture_word_t);

    // plain byte array, infers block ram.
    logic [dw-1:0] mem [capt_depth];

    // write port.
    always_ff @(posedge adcclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data.raw;
        end
    end

    // read port, one cycle from rd_en to rd_data.
    // holding rd_en low freezes the output, the drain logic leans on that.
    always_ff @(posedge adcclk) begin
        if (rd_en) begin
            rd_data.raw <= mem[rd_addr];
        end
    end

endmodule

/* common/gnss_pkg.sv */
/* sample types, capture word and quantizer table for the gnss front end.
   rtl and testbench refer to these by gnss_pkg:: scoped names. */
package gnss_pkg;

    // one raw adc code per pin pair, offset binary from the front-end chip.
    typedef logic [1:0] adc_code_t;

    // one baseband level, two's complement.
    typedef logic signed [3:0] bb_sample_t;

    // imag sits in the upper nibble, real in the lower.
    typedef struct packed {
        bb_sample_t im;
        bb_sample_t re;
    } iq_pair_t;

    // the ram only sees the raw byte.
    // readout and checking decode the same byte as an iq pair.
    typedef union packed {
        logic [7:0] raw;
        iq_pair_t   iq;
    } capture_word_t;

    // decimation, keep one sample in dec+1.
    typedef logic [4:0] dec_t;

    // code to level map of the front-end chip.
    // codes 0..3 give -6, -2, +2, +6.
    localparam bb_sample_t QUANT_LUT [4] = '{
        -4'sd6,
        -4'sd2,
        4'sd2,
        4'sd6
    };

    // 32 samples per chip over 1023 chips.
    localparam int DEFAULT_EPOCH_LEN = 32 * 1023;

    // 64k capture words.
    localparam int DEFAULT_CAPT_DEPTH = 65536;

endpackage

/* rtl/epoch_timer.sv */
/* sample counter that flags the last sample of every code epoch.
   epoch is combinational and coincides with the flagged sample. */
`timescale 1ns/100ps

module epoch_timer #(
    parameter int epoch_len = gnss_pkg::DEFAULT_EPOCH_LEN
) (
    input  logic adcclk,
    input  logic arst_n,
    input  logic bb_valid,
    output logic epoch
);

    // at least one bit even for a degenerate length.
    localparam int cnt_w = (epoch_len > 1) ? $clog2(epoch_len) : 1;
    localparam logic [cnt_w-1:0] last_cnt = cnt_w'(epoch_len - 1);

    logic [cnt_w-1:0] cnt;
    logic             wrap;

    // cnt holds the index of the current sample within its epoch.
    assign wrap = (cnt == last_cnt);

    always_ff @(posedge adcclk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (bb_valid) begin
            if (wrap) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // sample k carries epoch when k+1 is a multiple of epoch_len.
    assign epoch = bb_valid && wrap;

    // one cycle wide since the counter has moved on by the next sample.
    a_epoch_single: assert property (
        @(posedge adcclk) disable iff (!arst_n)
        epoch |=> !epoch
    );

endmodule

/* rtl/gnss_frontend_top.sv */
/* gnss front-end sample path: quantizer, epoch timer and epoch-aligned capture.
   epoch_len and capt_depth are set here and passed to the blocks. */
`timescale 1ns/100ps

module gnss_frontend_top #(
    parameter int epoch_len  = gnss_pkg::DEFAULT_EPOCH_LEN,
    parameter int capt_depth = gnss_pkg::DEFAULT_CAPT_DEPTH
) (
    input  logic                    adcclk,
    input  logic                    arst_n,
    input  gnss_pkg::adc_code_t     adc_i,
    input  gnss_pkg::adc_code_t     adc_q,
    input  logic                    start,
    input  gnss_pkg::dec_t          dec,
    input  logic                    cap_ready,
    output logic                    epoch,
    output logic                    busy,
    output logic                    done,
    output logic                    cap_valid,
    output gnss_pkg::capture_word_t cap_data
);

    localparam int aw = $clog2(capt_depth);

    // quantized stream.
    logic                 bb_valid;
    gnss_pkg::bb_sample_t bb_imag;
    gnss_pkg::bb_sample_t bb_real;

    // capture ram port.
    logic                    wr_en;
    logic [aw-1:0]           wr_addr;
    gnss_pkg::capture_word_t wr_data;
    logic                    rd_en;
    logic [aw-1:0]           rd_addr;
    gnss_pkg::capture_word_t rd_data;

    sample_quantizer sample_quantizer_inst (
        .adcclk   (adcclk),
        .arst_n   (arst_n),
        .adc_i    (adc_i),
        .adc_q    (adc_q),
        .bb_valid (bb_valid),
        .bb_imag  (bb_imag),
        .bb_real  (bb_real)
    );

    epoch_timer #(
        .epoch_len (epoch_len)
    ) epoch_timer_inst (
        .adcclk   (adcclk),
        .arst_n   (arst_n),
        .bb_valid (bb_valid),
        .epoch    (epoch)
    );

    // capture is aligned to the local epoch.
    capture_ctrl #(
        .capt_depth (capt_depth)
    ) capture_ctrl_inst (
        .adcclk    (adcclk),
        .arst_n    (arst_n),
        .start     (start),
        .dec       (dec),
        .bb_valid  (bb_valid),
        .bb_imag   (bb_imag),
        .bb_real   (bb_real),
        .epoch     (epoch),
        .rd_data   (rd_data),
        .cap_ready (cap_ready),
        .busy      (busy),
        .done      (done),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .cap_valid (cap_valid),
        .cap_data  (cap_data)
    );

    capture_ram #(
        .capt_depth (capt_depth)
    ) capture_ram_inst (
        .adcclk  (adcclk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* rtl/sample_quantizer.sv */
/* input register and 2-bit to 4-bit level map for the i and q adc pins.
   output stream is valid every cycle from the third cycle out of reset. */
`timescale 1ns/100ps

module sample_quantizer (
    input  logic                 adcclk,
    input  logic                 arst_n,
    input  gnss_pkg::adc_code_t  adc_i,
    input  gnss_pkg::adc_code_t  adc_q,
    output logic                 bb_valid,
    output gnss_pkg::bb_sample_t bb_imag,
    output gnss_pkg::bb_sample_t bb_real
);

    gnss_pkg::adc_code_t adc_i_reg;
    gnss_pkg::adc_code_t adc_q_reg;
    logic [1:0]          vld_pipe;

    // first stage, meant to land in the io registers.
    always_ff @(posedge adcclk) begin
        adc_i_reg <= adc_i;
        adc_q_reg <= adc_q;
    end

    // second stage, table lookup.
    // i pin goes to imag and q pin goes to real.
    always_ff @(posedge adcclk) begin
        bb_imag <= gnss_pkg::QUANT_LUT[adc_i_reg];
        bb_real <= gnss_pkg::QUANT_LUT[adc_q_reg];
    end

    // a one shifts in behind the two data stages.
    // so valid lines up with the first real quantized word.
    always_ff @(posedge adcclk or negedge arst_n) begin
        if (!arst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[0], 1'b1};
        end
    end

    assign bb_valid = vld_pipe[1];

    // the stream has no gaps once running.
    // downstream sample counting relies on this.
    a_valid_sticky: assert property (
        @(posedge adcclk) disable iff (!arst_n)
        bb_valid |=> bb_valid
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the gnss front-end testbench with Verilator, runs it into sim.log,
# and decides pass or fail from the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module tb_gnss_frontend -Mdir obj_dir -o sim_gnss > build.log 2>&1 \
    && ./obj_dir/sim_gnss > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* test/tb_gnss_frontend.sv */
/* testbench for the gnss front end: random adc pins, epoch and capture checks.
   runs five tests in sequence and prints a line per test and a closing count. */
`timescale 1ns/100ps

module tb_gnss_frontend;

    localparam int ep_len   = 64;
    localparam int depth    = 32;
    // edge at which reset is released, sample 0 comes from the pins driven here.
    localparam int rel_edge = 9;

    logic                    adcclk    = 1'b0;
    logic                    arst_n    = 1'b0;
    gnss_pkg::adc_code_t     adc_i     = '0;
    gnss_pkg::adc_code_t     adc_q     = '0;
    logic                    start     = 1'b0;
    gnss_pkg::dec_t          dec       = '0;
    logic                    cap_ready = 1'b1;
    logic                    epoch;
    logic                    busy;
    logic                    done;
    logic                    cap_valid;
    gnss_pkg::capture_word_t cap_data;

    integer                  seed = 72;
    logic [31:0]             rnd;
    int                      edge_cnt = 0;
    // driven pins per edge, i in bits 3:2 and q in bits 1:0.
    logic [3:0]              drive_log [$];
    int                      exp_idx [depth];
    int                      start_edge;
    bit                      ready_random = 1'b0;
    bit                      timed_out = 1'b0;
    int                      err_cnt = 0;
    int                      pass_cnt = 0;
    int                      fail_cnt = 0;
    int                      rx_cnt = 0;
    int                      done_rises = 0;
    int                      epoch_seen = 0;
    int                      cur_k;
    bit                      stalled_prev = 1'b0;
    bit                      done_prev = 1'b0;
    gnss_pkg::capture_word_t held_word;

    gnss_frontend_top #(
        .epoch_len  (ep_len),
        .capt_depth (depth)
    ) gnss_frontend_top_inst (
        .adcclk    (adcclk),
        .arst_n    (arst_n),
        .adc_i     (adc_i),
        .adc_q     (adc_q),
        .start     (start),
        .dec       (dec),
        .cap_ready (cap_ready),
        .epoch     (epoch),
        .busy      (busy),
        .done      (done),
        .cap_valid (cap_valid),
        .cap_data  (cap_data)
    );

    always #5 adcclk = ~adcclk;

    // one random word per edge feeds both pins and the ready pattern.
    always @(posedge adcclk) begin
        rnd = $random(seed);
        adc_i <= rnd[1:0];
        adc_q <= rnd[3:2];
        cap_ready <= ready_random ? rnd[4] : 1'b1;
        drive_log.push_back({rnd[1:0], rnd[3:2]});
        if (edge_cnt == rel_edge) begin
            arst_n <= 1'b1;
        end
        edge_cnt <= edge_cnt + 1;
    end

    // levels are 4 apart and centered on zero.
    function automatic gnss_pkg::capture_word_t expected_word(input logic [3:0] pins);
        gnss_pkg::capture_word_t w;
        w.iq.im = 4'(4 * int'(pins[3:2]) - 6);
        w.iq.re = 4'(4 * int'(pins[1:0]) - 6);
        return w;
    endfunction

    // the FSM is armed from edge s+2, so epochs of samples below s-10 are missed.
    function automatic void capture_indices(input int s_edge, input int dec_v,
                                            output int idx [depth]);
        int k;
        int j;
        k = s_edge - rel_edge - 1;
        if (k < 0) begin
            k = 0;
        end
        while ((k + 1) % ep_len != 0) begin
            k++;
        end
        for (j = 0; j < depth; j++) begin
            idx[j] = k + 1 + j * (dec_v + 1);
        end
    endfunction

    // index of the sample on the quantizer output during the current cycle.
    function automatic int sample_idx();
        return edge_cnt - rel_edge - 3;
    endfunction

    task automatic check_word(input gnss_pkg::capture_word_t got,
                              input gnss_pkg::capture_word_t exp, input string what);
        if (got.iq.im !== exp.iq.im || got.iq.re !== exp.iq.re) begin
            err_cnt++;
            $display("Error: %0t ns: %s is im %0d re %0d, expected im %0d re %0d",
                     $time, what, got.iq.im, got.iq.re, exp.iq.im, exp.iq.re);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_cnt++;
            $display("Error: %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            err_cnt++;
            $display("Error: %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // compares on the falling edge, where every DUT output is settled.
    always @(negedge adcclk) begin
        if (arst_n) begin
            cur_k = sample_idx();
            check_flag(epoch, (cur_k >= 0) && ((cur_k + 1) % ep_len == 0), "epoch");
            if (epoch) begin
                epoch_seen++;
            end
            if (stalled_prev) begin
                check_flag(cap_valid, 1'b1, "stalled cap_valid");
                check_word(cap_data, held_word, "stalled cap_data");
            end
            if (cap_valid && cap_ready) begin
                if (rx_cnt < depth) begin
                    check_word(cap_data, expected_word(drive_log[rel_edge + exp_idx[rx_cnt]]),
                               $sformatf("word %0d", rx_cnt));
                end else begin
                    check_count(rx_cnt + 1, depth, "readout words");
                end
                rx_cnt++;
            end
            stalled_prev = cap_valid && !cap_ready;
            held_word = cap_data;
            if (done && !done_prev) begin
                done_rises++;
            end
            done_prev = done;
        end
    end

    task automatic report_test(input string name, input int errs0);
        if (err_cnt == errs0 && !timed_out) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, err_cnt - errs0);
        end
    endtask

    task automatic wait_epochs(input int n);
        int errs0;
        int target;
        int cycles;
        errs0 = err_cnt;
        target = epoch_seen + n;
        cycles = 0;
        while (epoch_seen < target && cycles < ep_len * (n + 1) + 20) begin
            @(posedge adcclk);
            cycles++;
        end
        if (epoch_seen < target) begin
            timed_out = 1'b1;
            $display("timeout: only %0d epoch pulses seen", epoch_seen);
        end
        report_test("epoch spacing", errs0);
    endtask

    task automatic run_capture(input string name, input int dec_v, input bit rand_ready,
                               input bit restart);
        int errs0;
        int cycles;
        int limit;
        errs0 = err_cnt;
        limit = 2 * ep_len + depth * (dec_v + 1) + 8 * depth + 50;
        @(negedge adcclk);
        ready_random = rand_ready;
        rx_cnt = 0;
        done_rises = 0;
        @(posedge adcclk);
        start_edge = edge_cnt;
        capture_indices(start_edge, dec_v, exp_idx);
        start <= 1'b1;
        dec <= 5'(dec_v);
        @(posedge adcclk);
        start <= 1'b0;
        @(negedge adcclk);
        check_flag(busy, 1'b1, "busy after start");
        check_flag(done, 1'b0, "done after start");
        cycles = 0;
        if (restart) begin
            // a second start and a new dec in the middle of fill must change nothing.
            while (sample_idx() <= exp_idx[2] && cycles < limit) begin
                @(posedge adcclk);
                cycles++;
            end
            start <= 1'b1;
            dec <= 5'd5;
            @(posedge adcclk);
            start <= 1'b0;
        end
        while (!(rx_cnt == depth && done) && cycles < limit) begin
            @(posedge adcclk);
            cycles++;
        end
        if (cycles >= limit) begin
            timed_out = 1'b1;
            $display("timeout: %s got %0d of %0d words in %0d cycles",
                     name, rx_cnt, depth, limit);
        end else begin
            // a few idle cycles so that a stray extra word would be counted.
            repeat (4) @(posedge adcclk);
            @(negedge adcclk);
            check_count(rx_cnt, depth, "readout words");
            check_count(done_rises, 1, "done rises");
            check_flag(busy, 1'b0, "busy after readout");
            check_flag(done, 1'b1, "done after readout");
            check_flag(cap_valid, 1'b0, "cap_valid after readout");
        end
        ready_random = 1'b0;
        report_test(name, errs0);
    endtask

    initial begin
        wait_epochs(3);
        if (!timed_out) begin
            run_capture("full-rate capture", 0, 1'b0, 1'b0);
        end
        if (!timed_out) begin
            run_capture("decimated capture", 3, 1'b0, 1'b0);
        end
        if (!timed_out) begin
            run_capture("back-pressure", 0, 1'b1, 1'b0);
        end
        if (!timed_out) begin
            run_capture("start while busy", 0, 1'b0, 1'b1);
        end
        $display("tests: %0d passed, %0d failed, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (timed_out || err_cnt != 0 || fail_cnt != 0) begin
            $display("RESULT: FAIL");
        end else begin
            $display("RESULT: PASS");
        end
        $finish;
    end

endmodule
